//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
verilator --binary --timing --top-module wakeup_tb -f wakeup.f -o wakeup_sim > build.log 2>&1 \
    && ./obj_dir/wakeup_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

//--- test/wakeup_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wakeup_tb;
    import backend_types_pkg::*;
    import wakeup_pkg::*;

    localparam int TEST_CYCLES = 900;
    localparam int MARGIN = 400;

    logic          clk = 1'b0;
    logic          rst_n = 1'b0;
    wakeup_req_t   int_wakeup [4];
    wakeup_req_t   load_wakeup [2];
    wakeup_req_t   csr_wakeup, mult_wakeup, div_wakeup;
    logic [3:0]    int_wakeup_ready;
    wakeup_req_t   wakeup_bus [6];
    logic          dispatch_valid, dispatch_ready, issue_valid, issue_ready;
    dispatch_pkt_t dispatch_pkt;
    issue_pkt_t    issue_pkt;

    // Model state from the wakeup and queue rules
    logic          m_rdy [64];
    logic [7:0]    q_v, q_r1, q_r2;
    dispatch_pkt_t q_pkt [8];
    logic          o_v, hold, saw_full, found;
    issue_pkt_t    o_pkt, held_pkt;
    wakeup_req_t   exp_bus [6];
    logic          issued_seen [256];
    int            errors = 0, issued_cnt = 0, sel, free_i, tests = 0;
    logic [31:0]   rng = 32'd22;
    logic [7:0]    next_tag = 8'd0;

    wakeup_top wakeup_top_inst (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // Unit that owns an ALU slot or '0 when unshared
    function automatic wakeup_req_t slot_owner(input int i);
        if (i == 0) return csr_wakeup;
        if (i == 2) return mult_wakeup;
        if (i == 3) return div_wakeup;
        return '0;
    endfunction

    function automatic wakeup_req_t ref_slot(input int i);
        wakeup_req_t o;
        if (i >= 4) return load_wakeup[i-4];
        o = slot_owner(i);
        return o.en ? o : int_wakeup[i];
    endfunction

    // ALU slot is stalled while its owning unit announces
    function automatic logic expected_ready(input int i);
        wakeup_req_t o;
        o = slot_owner(i);
        return ~o.en;
    endfunction

    function automatic logic bus_wakes(input preg_idx_t r);
        for (int b = 0; b < 6; b++) begin
            if (exp_bus[b].en && exp_bus[b].we && exp_bus[b].rd == r) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic report_error(input string msg);
        $display("error @%0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 64; r++) m_rdy[r] = 1'b1;
            q_v = '0;
            o_v = 1'b0;
            hold = 1'b0;
        end
        else begin
            for (int i = 0; i < 6; i++) begin
                exp_bus[i] = ref_slot(i);
                if (wakeup_bus[i] !== exp_bus[i]) report_error($sformatf("bus slot %0d", i));
            end
            for (int i = 0; i < 4; i++) begin
                if (int_wakeup_ready[i] !== expected_ready(i))
                    report_error($sformatf("int_wakeup_ready[%0d]", i));
            end
            if (issue_valid !== o_v) report_error("issue_valid");
            if (o_v && issue_pkt !== o_pkt) report_error("issue_pkt");
            if (dispatch_ready !== ~&q_v) report_error("dispatch_ready");
            if (hold && (!issue_valid || issue_pkt !== held_pkt))
                report_error("issue_pkt changed under back-pressure");
            hold = issue_valid && !issue_ready;
            held_pkt = issue_pkt;
            if (!dispatch_ready) saw_full = 1'b1;
            if (issue_valid && issue_ready) begin
                if (issued_seen[issue_pkt.tag]) report_error("tag issued twice");
                issued_seen[issue_pkt.tag] = 1'b1;
                issued_cnt++;
            end
            // Select and free slot come from the old contents
            found = 1'b0;
            free_i = -1;
            for (int i = 7; i >= 0; i--) begin
                if (!q_v[i]) free_i = i;
                if (q_v[i] && q_r1[i] && q_r2[i]) begin
                    found = 1'b1;
                    sel = i;
                end
            end
            for (int i = 0; i < 8; i++) begin
                if (bus_wakes(q_pkt[i].src1)) q_r1[i] = 1'b1;
                if (bus_wakes(q_pkt[i].src2)) q_r2[i] = 1'b1;
            end
            if (!o_v || issue_ready) begin
                o_v = found;
                if (found) begin
                    o_pkt = '{tag: q_pkt[sel].tag, dst: q_pkt[sel].dst, dst_we: q_pkt[sel].dst_we};
                    q_v[sel] = 1'b0;
                end
            end
            if (dispatch_valid && free_i >= 0) begin
                q_v[free_i] = 1'b1;
                q_pkt[free_i] = dispatch_pkt;
                q_r1[free_i] = m_rdy[dispatch_pkt.src1] | bus_wakes(dispatch_pkt.src1);
                q_r2[free_i] = m_rdy[dispatch_pkt.src2] | bus_wakes(dispatch_pkt.src2);
                if (dispatch_pkt.dst_we) m_rdy[dispatch_pkt.dst] = 1'b0;
            end
            for (int i = 0; i < 6; i++) begin
                if (exp_bus[i].en && exp_bus[i].we) m_rdy[exp_bus[i].rd] = 1'b1;
            end
        end
    end

    task automatic clear_sources();
        for (int i = 0; i < 4; i++) int_wakeup[i] = '0;
        for (int i = 0; i < 2; i++) load_wakeup[i] = '0;
        csr_wakeup = '0;
        mult_wakeup = '0;
        div_wakeup = '0;
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input preg_idx_t s1, input preg_idx_t s2, input preg_idx_t d,
                        input logic we, output logic [7:0] tag);
        tag = next_tag;
        next_tag++;
        dispatch_valid = 1'b1;
        dispatch_pkt = '{src1: s1, src2: s2, dst: d, dst_we: we, tag: tag};
        while (!dispatch_ready) @(negedge clk);
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (|q_v || o_v) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN) * 10);
        $display("watchdog: simulation timed out waiting for the DUT");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [7:0] ta, tb, tc [3];
        clear_sources();
        dispatch_valid = 1'b0;
        dispatch_pkt = '0;
        issue_ready = 1'b1;
        saw_full = 1'b0;
        for (int t = 0; t < 256; t++) issued_seen[t] = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int c = 0; c < 200; c++) begin
            for (int i = 0; i < 4; i++) begin
                rng = xorshift(rng);
                int_wakeup[i] = rng[7:0];
            end
            rng = xorshift(rng);
            csr_wakeup = rng[7:0];
            mult_wakeup = rng[15:8];
            div_wakeup = rng[23:16];
            load_wakeup[0] = rng[31:24];
            rng = xorshift(rng);
            load_wakeup[1] = rng[7:0];
            @(negedge clk);
        end
        clear_sources();
        finish_test("slot sharing");
        finish_test("load pass-through");

        send(6'd1, 6'd2, 6'd10, 1'b1, ta);
        send(6'd10, 6'd1, 6'd11, 1'b0, tb);
        int_wakeup[1] = '{en: 1'b1, we: 1'b0, rd: 6'd10};
        repeat (10) @(negedge clk);
        if (issued_seen[tb]) report_error("issued after wakeup without we");
        int_wakeup[1] = '{en: 1'b1, we: 1'b1, rd: 6'd10};
        @(negedge clk);
        clear_sources();
        while (!issued_seen[tb]) @(negedge clk);
        finish_test("write-enable filter");

        for (int k = 0; k < 3; k++) send(6'd1, 6'd2, 6'(20 + k), 1'b1, ta);
        for (int k = 0; k < 3; k++) send(6'(20 + k), 6'(22 - k), 6'd40, 1'b1, tc[k]);
        repeat (5) @(negedge clk);
        for (int k = 0; k < 3; k++) begin
            if (issued_seen[tc[k]]) report_error("issued before its sources woke");
        end
        int_wakeup[1] = '{en: 1'b1, we: 1'b1, rd: 6'd20};
        load_wakeup[0] = '{en: 1'b1, we: 1'b1, rd: 6'd21};
        csr_wakeup = '{en: 1'b1, we: 1'b1, rd: 6'd22};
        @(negedge clk);
        clear_sources();
        wait_idle();
        finish_test("wakeup then issue");

        for (int c = 0; c < 300; c++) begin
            rng = xorshift(rng);
            issue_ready = rng[0] & rng[1];
            int_wakeup[1] = '{en: rng[2], we: 1'b1, rd: rng[13:8]};
            if (rng[5:4] != 2'b00 && dispatch_ready)
                send(rng[21:16], rng[29:24], rng[13:8] ^ 6'h15, rng[6], ta);
            else
                @(negedge clk);
        end
        issue_ready = 1'b1;
        for (int r = 0; r < 64; r += 2) begin
            load_wakeup[0] = '{en: 1'b1, we: 1'b1, rd: 6'(r)};
            load_wakeup[1] = '{en: 1'b1, we: 1'b1, rd: 6'(r + 1)};
            @(negedge clk);
        end
        clear_sources();
        wait_idle();
        if (issued_cnt != next_tag) report_error("dispatched tag never issued");
        if (!saw_full) begin
            $display("dispatch_ready never fell with the queue full");
            errors++;
        end
        finish_test("back-pressure");

        send(6'd3, 6'd4, 6'd50, 1'b1, ta);
        @(negedge clk);
        if (!issue_valid || issue_pkt.tag !== ta) report_error("no issue one cycle after dispatch");
        wait_idle();
        finish_test("immediate issue");

        $display("tests %0d, issued %0d, errors %0d", tests, issued_cnt, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/backend_types_pkg.sv
`default_nettype none

package backend_types_pkg;

    // Physical register file geometry
    localparam int PREG_WIDTH = 6;
    localparam int NUM_PREG = 64;

    // Physical register index
    typedef logic [PREG_WIDTH-1:0] preg_idx_t;

    // One bit per physical register
    typedef logic [NUM_PREG-1:0] preg_mask_t;

    // High when the instruction really writes its destination
    typedef logic reg_we_t;

endpackage

`default_nettype wire

//--- verilog/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int IQ_DEPTH      = 8,
    parameter int ALU_SIZE      = 4,
    parameter int LOAD_PIPELINE = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dispatch_valid,
    input  wakeup_pkg::dispatch_pkt_t     dispatch_pkt,
    output logic                          dispatch_ready,
    input  wakeup_pkg::wakeup_req_t       wakeup_bus [ALU_SIZE+LOAD_PIPELINE],
    input  backend_types_pkg::preg_mask_t preg_ready,
    output logic                          alloc_en,
    output backend_types_pkg::preg_idx_t  alloc_dst,
    output logic                          issue_valid,
    output wakeup_pkg::issue_pkt_t        issue_pkt,
    input  logic                          issue_ready
);
    import backend_types_pkg::*;
    import wakeup_pkg::*;

    localparam int WB_SIZE = ALU_SIZE + LOAD_PIPELINE;
    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [IQ_DEPTH-1:0] ent_valid;
    dispatch_pkt_t       ent_pkt [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] ent_rdy1;
    logic [IQ_DEPTH-1:0] ent_rdy2;

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_found;
    logic             disp_fire;
    logic             disp_rdy1;
    logic             disp_rdy2;
    logic             issue_load;

    // Any bus slot announcing a real write to this register
    function automatic logic woken(input preg_idx_t src);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < WB_SIZE; b++) begin
            if (wakeup_bus[b].en && wakeup_bus[b].we && wakeup_bus[b].rd == src) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign dispatch_ready = ~(&ent_valid);
    assign disp_fire = dispatch_valid && dispatch_ready;
    assign alloc_en = disp_fire && dispatch_pkt.dst_we;
    assign alloc_dst = dispatch_pkt.dst;

    // Output stage empty or draining this edge
    assign issue_load = !issue_valid || issue_ready;

    // Table value plus same-cycle bypass from the bus
    always_comb begin
        disp_rdy1 = preg_ready[dispatch_pkt.src1] | woken(dispatch_pkt.src1);
        disp_rdy2 = preg_ready[dispatch_pkt.src2] | woken(dispatch_pkt.src2);
    end

    // Lowest free entry and lowest ready entry
    always_comb begin
        free_idx = '0;
        sel_idx = '0;
        sel_found = 1'b0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (ent_valid[i] && ent_rdy1[i] && ent_rdy2[i]) begin
                sel_found = 1'b1;
                sel_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid <= '0;
            issue_valid <= 1'b0;
        end
        else begin
            if (issue_load) begin
                issue_valid <= sel_found;
                if (sel_found) begin
                    ent_valid[sel_idx] <= 1'b0;
                end
            end
            // Never the same entry as the one being freed
            if (disp_fire) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Bus matches for waiting sources
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (woken(ent_pkt[i].src1)) begin
                ent_rdy1[i] <= 1'b1;
            end
            if (woken(ent_pkt[i].src2)) begin
                ent_rdy2[i] <= 1'b1;
            end
        end
        if (disp_fire) begin
            ent_pkt[free_idx] <= dispatch_pkt;
            ent_rdy1[free_idx] <= disp_rdy1;
            ent_rdy2[free_idx] <= disp_rdy2;
        end
        if (issue_load && sel_found) begin
            issue_pkt <= '{tag: ent_pkt[sel_idx].tag,
                           dst: ent_pkt[sel_idx].dst,
                           dst_we: ent_pkt[sel_idx].dst_we};
        end
    end

endmodule

`default_nettype wire

//--- verilog/preg_ready_table.sv
`timescale 1ns/1ps
`default_nettype none

module preg_ready_table #(
    parameter int ALU_SIZE      = 4,
    parameter int LOAD_PIPELINE = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  wakeup_pkg::wakeup_req_t       wakeup_bus [ALU_SIZE+LOAD_PIPELINE],
    input  logic                          alloc_en,
    input  backend_types_pkg::preg_idx_t  alloc_dst,
    output backend_types_pkg::preg_mask_t preg_ready
);
    import backend_types_pkg::*;

    localparam int WB_SIZE = ALU_SIZE + LOAD_PIPELINE;

    preg_mask_t wake_set;
    preg_mask_t alloc_clr;

    // Only real writes mark a register as written back soon
    always_comb begin
        wake_set = '0;
        for (int i = 0; i < WB_SIZE; i++) begin
            if (wakeup_bus[i].en && wakeup_bus[i].we) begin
                wake_set[wakeup_bus[i].rd] = 1'b1;
            end
        end
    end

    // Newly renamed destination is not ready yet
    always_comb begin
        alloc_clr = '0;
        if (alloc_en) begin
            alloc_clr[alloc_dst] = 1'b1;
        end
    end

    // Architectural state is ready out of reset
    // Set applied after clear lets wakeup win on the same register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            preg_ready <= '1;
        end
        else begin
            preg_ready <= (preg_ready & ~alloc_clr) | wake_set;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wakeup_merge.sv
`timescale 1ns/1ps
`default_nettype none

module wakeup_merge #(
    parameter int ALU_SIZE      = 4,
    parameter int LOAD_PIPELINE = 2,
    parameter int HAS_MULDIV    = 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  wakeup_pkg::wakeup_req_t int_wakeup [ALU_SIZE],
    input  wakeup_pkg::wakeup_req_t load_wakeup [LOAD_PIPELINE],
    input  wakeup_pkg::wakeup_req_t csr_wakeup,
    input  wakeup_pkg::wakeup_req_t mult_wakeup,
    input  wakeup_pkg::wakeup_req_t div_wakeup,
    output logic [ALU_SIZE-1:0]     int_wakeup_ready,
    output wakeup_pkg::wakeup_req_t wakeup_bus [ALU_SIZE+LOAD_PIPELINE]
);
    import wakeup_pkg::*;

    generate
        for (genvar i = 0; i < ALU_SIZE; i++) begin : g_alu_slot
            // Unit that owns this slot when it announces
            wakeup_req_t shared_req;

            if (i == 0) begin : g_csr
                assign shared_req = csr_wakeup;
            end
            else if (HAS_MULDIV != 0 && i == 2) begin : g_mult
                assign shared_req = mult_wakeup;
            end
            else if (HAS_MULDIV != 0 && i == 3) begin : g_div
                assign shared_req = div_wakeup;
            end
            else begin : g_plain
                assign shared_req = '0;
            end

            // Shared unit wins and stalls the ALU announcement
            assign int_wakeup_ready[i] = ~shared_req.en;
            assign wakeup_bus[i] = shared_req.en ? shared_req : int_wakeup[i];
        end

        // Load slots sit above the ALU slots
        for (genvar j = 0; j < LOAD_PIPELINE; j++) begin : g_load_slot
            assign wakeup_bus[ALU_SIZE+j] = load_wakeup[j];
        end
    endgenerate

endmodule

`default_nettype wire

//--- verilog/wakeup_pkg.sv
`default_nettype none

package wakeup_pkg;

    // Opaque instruction id, carried through the queue untouched
    typedef logic [7:0] iq_tag_t;

    // One wakeup announcement from an execution source
    typedef struct packed {
        logic                         en;
        backend_types_pkg::reg_we_t   we;
        backend_types_pkg::preg_idx_t rd;
    } wakeup_req_t;

    // Instruction entering the issue queue
    typedef struct packed {
        backend_types_pkg::preg_idx_t src1;
        backend_types_pkg::preg_idx_t src2;
        backend_types_pkg::preg_idx_t dst;
        backend_types_pkg::reg_we_t   dst_we;
        iq_tag_t                      tag;
    } dispatch_pkt_t;

    // Instruction leaving the issue queue
    typedef struct packed {
        iq_tag_t                      tag;
        backend_types_pkg::preg_idx_t dst;
        backend_types_pkg::reg_we_t   dst_we;
    } issue_pkt_t;

endpackage

`default_nettype wire

//--- verilog/wakeup_top.sv
`timescale 1ns/1ps
`default_nettype none

module wakeup_top #(
    parameter int ALU_SIZE      = 4,
    parameter int LOAD_PIPELINE = 2,
    parameter int HAS_MULDIV    = 1,
    parameter int IQ_DEPTH      = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  wakeup_pkg::wakeup_req_t   int_wakeup [ALU_SIZE],
    input  wakeup_pkg::wakeup_req_t   load_wakeup [LOAD_PIPELINE],
    input  wakeup_pkg::wakeup_req_t   csr_wakeup,
    input  wakeup_pkg::wakeup_req_t   mult_wakeup,
    input  wakeup_pkg::wakeup_req_t   div_wakeup,
    output logic [ALU_SIZE-1:0]       int_wakeup_ready,
    output wakeup_pkg::wakeup_req_t   wakeup_bus [ALU_SIZE+LOAD_PIPELINE],
    input  logic                      dispatch_valid,
    input  wakeup_pkg::dispatch_pkt_t dispatch_pkt,
    output logic                      dispatch_ready,
    output logic                      issue_valid,
    output wakeup_pkg::issue_pkt_t    issue_pkt,
    input  logic                      issue_ready
);
    import backend_types_pkg::*;

    preg_mask_t preg_ready;
    logic       alloc_en;
    preg_idx_t  alloc_dst;

    wakeup_merge #(
        .ALU_SIZE      (ALU_SIZE),
        .LOAD_PIPELINE (LOAD_PIPELINE),
        .HAS_MULDIV    (HAS_MULDIV)
    ) wakeup_merge_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .int_wakeup       (int_wakeup),
        .load_wakeup      (load_wakeup),
        .csr_wakeup       (csr_wakeup),
        .mult_wakeup      (mult_wakeup),
        .div_wakeup       (div_wakeup),
        .int_wakeup_ready (int_wakeup_ready),
        .wakeup_bus       (wakeup_bus)
    );

    // Ready table sits beside the queue it steers
    preg_ready_table #(
        .ALU_SIZE      (ALU_SIZE),
        .LOAD_PIPELINE (LOAD_PIPELINE)
    ) preg_ready_table_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wakeup_bus (wakeup_bus),
        .alloc_en   (alloc_en),
        .alloc_dst  (alloc_dst),
        .preg_ready (preg_ready)
    );

    issue_queue #(
        .IQ_DEPTH      (IQ_DEPTH),
        .ALU_SIZE      (ALU_SIZE),
        .LOAD_PIPELINE (LOAD_PIPELINE)
    ) issue_queue_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_pkt   (dispatch_pkt),
        .dispatch_ready (dispatch_ready),
        .wakeup_bus     (wakeup_bus),
        .preg_ready     (preg_ready),
        .alloc_en       (alloc_en),
        .alloc_dst      (alloc_dst),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt),
        .issue_ready    (issue_ready)
    );

endmodule

`default_nettype wire

//--- wakeup.f
verilog/backend_types_pkg.sv
verilog/wakeup_pkg.sv
verilog/wakeup_merge.sv
verilog/preg_ready_table.sv
verilog/issue_queue.sv
verilog/wakeup_top.sv
test/wakeup_tb.sv
